/* hdl/regfile_pkg.sv */
/*
 * Physical register file package
 * Widths, decode/issue/writeback packets and the init sequencer states
 */
package regfile_pkg;

    // Operand width and source operand count
    localparam int DATA_W     = 32;
    localparam int READ_PORTS = 2;

    // Up to 64 physical registers
    typedef logic [5:0] phys_addr_t;
    typedef logic [0:0] wb_group_t;

    // Decode side, sampled on advance
    typedef struct packed {
        logic                                advance;
        logic                                uses_rd;
        phys_addr_t                          rd_addr;
        phys_addr_t [READ_PORTS-1:0]         rs_addr;
        wb_group_t  [READ_PORTS-1:0]         rs_group;
    } decode_req_t;

    // Issue side, done marks a single-cycle result complete
    typedef struct packed {
        logic                                done;
        phys_addr_t                          rd_addr;
        phys_addr_t [READ_PORTS-1:0]         rs_addr;
    } issue_req_t;

    typedef struct packed {
        logic [READ_PORTS-1:0][DATA_W-1:0]   data;
        logic [READ_PORTS-1:0]               inuse;
    } issue_rsp_t;

    // One commit per writeback group
    typedef struct packed {
        logic                                valid;
        phys_addr_t                          addr;
        logic [DATA_W-1:0]                   data;
    } wb_packet_t;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_CLEAR, SEQ_RUN} seq_state_t;

endpackage

/* hdl/toggle_memory.sv */
/*
 * In-use tracker
 * One bit array per update port, each port only flips its own bits,
 * read value is the XOR of all arrays at the read address
 */
module toggle_memory #(
    parameter int PHYS_REGS = 64,
    parameter int NUM_PORTS = 4
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    clear,
    input  logic                    toggle      [NUM_PORTS],
    input  regfile_pkg::phys_addr_t toggle_addr [NUM_PORTS],
    input  regfile_pkg::phys_addr_t read_addr   [regfile_pkg::READ_PORTS],
    output logic                    inuse       [regfile_pkg::READ_PORTS]
);
    import regfile_pkg::*;

    // Per-port toggle arrays
    logic [PHYS_REGS-1:0] bits [NUM_PORTS];

    //////////////////////////////////////////////////////////////////////////////
    // Update
    // Several ports may fire per cycle, never on the same address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                bits[p] <= '0;
            end
        end else if (clear) begin
            // Bulk clear of every array in one cycle
            for (int p = 0; p < NUM_PORTS; p++) begin
                bits[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (toggle[p]) begin
                    bits[p][toggle_addr[p]] <= ~bits[p][toggle_addr[p]];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Read
    // Odd number of flips means set but not yet released
    always_comb begin
        for (int r = 0; r < READ_PORTS; r++) begin
            inuse[r] = 1'b0;
            for (int p = 0; p < NUM_PORTS; p++) begin
                inuse[r] ^= bits[p][read_addr[r]];
            end
        end
    end

endmodule

/* hdl/register_bank.sv */
/*
 * Register bank for one writeback group
 * Single write port, synchronous read ports enabled together
 */
module register_bank #(
    parameter int PHYS_REGS = 64
) (
    input  logic                             clk,
    input  logic                             we,
    input  regfile_pkg::phys_addr_t          waddr,
    input  logic [regfile_pkg::DATA_W-1:0]   wdata,
    input  regfile_pkg::phys_addr_t          raddr [regfile_pkg::READ_PORTS],
    input  logic                             re,
    output logic [regfile_pkg::DATA_W-1:0]   rdata [regfile_pkg::READ_PORTS]
);
    import regfile_pkg::*;

    // Storage, one RAM per group
    logic [DATA_W-1:0] mem [PHYS_REGS];

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read ports see the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (re) begin
            for (int r = 0; r < READ_PORTS; r++) begin
                rdata[r] <= mem[raddr[r]];
            end
        end
    end

endmodule

/* hdl/init_sequencer.sv */
/*
 * Init sequencer
 * Runs the register file clear after reset or on request, then reports ready
 */
module init_sequencer (
    input  logic clk,
    input  logic arst_n,
    input  logic clear_req,
    input  logic last,
    output logic clear_en,
    output logic ready
);
    import regfile_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    //////////////////////////////////////////////////////////////////////////////
    // FSM
    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE:  state_next = SEQ_CLEAR;
            // Walk ends on the final address
            SEQ_CLEAR: if (last) state_next = SEQ_RUN;
            SEQ_RUN:   if (clear_req) state_next = SEQ_CLEAR;
            default:   state_next = SEQ_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Outputs
    assign clear_en = (state == SEQ_CLEAR);
    assign ready    = (state == SEQ_RUN);

    //////////////////////////////////////////////////////////////////////////////
    // Assertions
    a_excl : assert property (@(posedge clk) disable iff (!arst_n)
        !(clear_en && ready));

endmodule

/* hdl/init_counter.sv */
/*
 * Init address walker
 * Steps through every physical register while clearing
 */
module init_counter #(
    parameter int PHYS_REGS = 64
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    clear_en,
    output regfile_pkg::phys_addr_t addr,
    output logic                    last
);
    import regfile_pkg::*;

    localparam phys_addr_t LAST_ADDR = phys_addr_t'(PHYS_REGS - 1);

    // Final address of the walk
    assign last = clear_en && (addr == LAST_ADDR);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr <= '0;
        end else if (!clear_en || last) begin
            addr <= '0;
        end else begin
            addr <= addr + 1'b1;
        end
    end

    a_addr_range : assert property (@(posedge clk) disable iff (!arst_n)
        addr <= LAST_ADDR);

endmodule

/* hdl/register_file.sv */
/*
 * Physical register file
 * In-use bookkeeping, per-group banks, operand capture on decode advance
 * and replacement of held operands by matching commits
 */
module register_file #(
    parameter int PHYS_REGS     = 64,
    parameter int NUM_WB_GROUPS = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     clear_en,
    input  regfile_pkg::phys_addr_t  clear_addr,
    input  logic                     flush,
    input  regfile_pkg::decode_req_t decode,
    input  regfile_pkg::issue_req_t  issue,
    input  regfile_pkg::wb_packet_t  commit [NUM_WB_GROUPS],
    output regfile_pkg::issue_rsp_t  operand
);
    import regfile_pkg::*;

    // Decode, issue, then one port per commit group
    localparam int NUM_TOGGLE = 2 + NUM_WB_GROUPS;

    logic              toggle_en   [NUM_TOGGLE];
    phys_addr_t        toggle_addr [NUM_TOGGLE];
    phys_addr_t        inuse_raddr [READ_PORTS];
    logic              inuse       [READ_PORTS];
    logic              zero_toggle;
    logic              commit_any;

    logic              commit_we  [NUM_WB_GROUPS];
    logic              bank_we    [NUM_WB_GROUPS];
    phys_addr_t        bank_waddr [NUM_WB_GROUPS];
    logic [DATA_W-1:0] bank_wdata [NUM_WB_GROUPS];
    phys_addr_t        rs_raddr   [READ_PORTS];
    logic [DATA_W-1:0] bank_rdata [NUM_WB_GROUPS][READ_PORTS];

    // Captured operand state
    wb_group_t         grp_r     [READ_PORTS];
    phys_addr_t        addr_r    [READ_PORTS];
    logic              use_held  [READ_PORTS];
    logic [DATA_W-1:0] held      [READ_PORTS];
    logic              fwd_hit   [READ_PORTS];
    logic [DATA_W-1:0] fwd_data  [READ_PORTS];
    logic              repl_hit  [READ_PORTS];
    logic [DATA_W-1:0] repl_data [READ_PORTS];

    //////////////////////////////////////////////////////////////////////////////
    // In-use tracking
    always_comb begin
        // Register 0 is never marked
        toggle_en[0]   = decode.advance && decode.uses_rd && (decode.rd_addr != '0) && !flush;
        toggle_addr[0] = decode.rd_addr;
        toggle_en[1]   = issue.done;
        toggle_addr[1] = issue.rd_addr;
        commit_any     = 1'b0;
        for (int g = 0; g < NUM_WB_GROUPS; g++) begin
            commit_we[g]       = commit[g].valid && (commit[g].addr != '0);
            toggle_en[2 + g]   = commit_we[g];
            toggle_addr[2 + g] = commit[g].addr;
            commit_any        |= commit[g].valid;
        end
        zero_toggle = 1'b0;
        for (int p = 0; p < NUM_TOGGLE; p++) begin
            zero_toggle |= toggle_en[p] && (toggle_addr[p] == '0);
        end
        // Unpack addresses for the array ports
        for (int r = 0; r < READ_PORTS; r++) begin
            inuse_raddr[r] = issue.rs_addr[r];
            rs_raddr[r]    = decode.rs_addr[r];
        end
    end

    toggle_memory #(
        .PHYS_REGS (PHYS_REGS),
        .NUM_PORTS (NUM_TOGGLE)
    ) u_inuse (
        .clk         (clk),
        .arst_n      (arst_n),
        .clear       (clear_en),
        .toggle      (toggle_en),
        .toggle_addr (toggle_addr),
        .read_addr   (inuse_raddr),
        .inuse       (inuse)
    );

    //////////////////////////////////////////////////////////////////////////////
    // Banks
    // Clear walk owns the write port while active
    always_comb begin
        for (int g = 0; g < NUM_WB_GROUPS; g++) begin
            bank_we[g]    = clear_en || commit_we[g];
            bank_waddr[g] = clear_en ? clear_addr : commit[g].addr;
            bank_wdata[g] = clear_en ? '0 : commit[g].data;
        end
    end

    for (genvar g = 0; g < NUM_WB_GROUPS; g++) begin : gen_bank
        register_bank #(
            .PHYS_REGS (PHYS_REGS)
        ) u_bank (
            .clk   (clk),
            .we    (bank_we[g]),
            .waddr (bank_waddr[g]),
            .wdata (bank_wdata[g]),
            .raddr (rs_raddr),
            .re    (decode.advance),
            .rdata (bank_rdata[g])
        );
    end

    //////////////////////////////////////////////////////////////////////////////
    // Operand capture and replacement
    always_comb begin
        for (int i = 0; i < READ_PORTS; i++) begin
            fwd_hit[i]   = 1'b0;
            fwd_data[i]  = '0;
            repl_hit[i]  = 1'b0;
            repl_data[i] = '0;
            for (int g = 0; g < NUM_WB_GROUPS; g++) begin
                // Same-cycle commit misses the bank read
                if (commit_we[g] && decode.rs_group[i] == wb_group_t'(g) &&
                        commit[g].addr == decode.rs_addr[i]) begin
                    fwd_hit[i]  = 1'b1;
                    fwd_data[i] = commit[g].data;
                end
                // Later producer of a held operand
                if (commit_we[g] && grp_r[i] == wb_group_t'(g) &&
                        commit[g].addr == addr_r[i]) begin
                    repl_hit[i]  = 1'b1;
                    repl_data[i] = commit[g].data;
                end
            end
            operand.data[i]  = use_held[i] ? held[i] : bank_rdata[grp_r[i]][i];
            operand.inuse[i] = inuse[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Zero word presented until the first advance
            for (int i = 0; i < READ_PORTS; i++) begin
                grp_r[i]    <= '0;
                addr_r[i]   <= '0;
                use_held[i] <= 1'b1;
                held[i]     <= '0;
            end
        end else begin
            for (int i = 0; i < READ_PORTS; i++) begin
                if (decode.advance) begin
                    grp_r[i]    <= decode.rs_group[i];
                    addr_r[i]   <= decode.rs_addr[i];
                    use_held[i] <= fwd_hit[i];
                    held[i]     <= fwd_data[i];
                end else if (repl_hit[i]) begin
                    use_held[i] <= 1'b1;
                    held[i]     <= repl_data[i];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Assertions
    a_quiet_clear : assert property (@(posedge clk) disable iff (!arst_n)
        clear_en |-> !decode.advance && !issue.done && !commit_any);

    a_no_zero_toggle : assert property (@(posedge clk) disable iff (!arst_n)
        !zero_toggle);

endmodule

/* hdl/regfile_top.sv */
/*
 * Register file subsystem top
 * Init sequencer, address walker and register file
 */
module regfile_top #(
    parameter int PHYS_REGS     = 64,
    parameter int NUM_WB_GROUPS = 2
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     clear_req,
    input  logic                     flush,
    input  regfile_pkg::decode_req_t decode,
    input  regfile_pkg::issue_req_t  issue,
    input  regfile_pkg::wb_packet_t  commit [NUM_WB_GROUPS],
    output logic                     ready,
    output regfile_pkg::issue_rsp_t  operand
);
    import regfile_pkg::*;

    // Clear control
    logic       clear_en;
    logic       last;
    phys_addr_t clear_addr;

    init_sequencer u_seq (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear_req (clear_req),
        .last      (last),
        .clear_en  (clear_en),
        .ready     (ready)
    );

    init_counter #(
        .PHYS_REGS (PHYS_REGS)
    ) u_cnt (
        .clk      (clk),
        .arst_n   (arst_n),
        .clear_en (clear_en),
        .addr     (clear_addr),
        .last     (last)
    );

    register_file #(
        .PHYS_REGS     (PHYS_REGS),
        .NUM_WB_GROUPS (NUM_WB_GROUPS)
    ) u_rf (
        .clk        (clk),
        .arst_n     (arst_n),
        .clear_en   (clear_en),
        .clear_addr (clear_addr),
        .flush      (flush),
        .decode     (decode),
        .issue      (issue),
        .commit     (commit),
        .operand    (operand)
    );

endmodule

/* test/tb_regfile_vectors.svh */
/*
 * Register file test vectors
 * One entry per operation, checked one cycle after it is applied
 */
`ifndef TB_REGFILE_VECTORS_SVH
`define TB_REGFILE_VECTORS_SVH

typedef enum logic [2:0] {OP_IDLE, OP_ADV, OP_DONE, OP_COMMIT, OP_CLEAR} op_t;

// Fixed entries expect zero data and the in-use pair below
// Other entries take data and in-use bits from the model
typedef struct packed {
    op_t        op;
    logic       flush;
    logic       uses_rd;
    logic [5:0] rd;         // destination for advance and done
    logic [5:0] rs0;
    logic       g0;
    logic [5:0] rs1;
    logic       g1;
    logic       cmt;        // commit alongside an advance
    logic [5:0] c_addr;
    logic       c_grp;
    logic       fixed;
    logic [1:0] exp_inuse;  // bit i for read port i
} vec_t;

localparam int NUM_VECS = 25;

// op          fl ur  rd rs0 g0 rs1 g1 cm  ca cg fx inuse
vec_t vecs [NUM_VECS] = '{
    // Mark, release by commit or done, register 0 never marked
    '{OP_ADV,    0, 1,  7,  7, 0,  0, 1, 0,  0, 0, 1, 2'b01},
    '{OP_COMMIT, 0, 0,  0,  7, 0,  0, 1, 0,  7, 0, 0, 2'b00},
    '{OP_ADV,    0, 1,  9,  9, 1,  7, 0, 0,  0, 0, 0, 2'b00},
    '{OP_COMMIT, 0, 0,  0,  9, 1,  7, 0, 0,  9, 1, 0, 2'b00},
    '{OP_ADV,    0, 1, 12, 12, 0,  0, 0, 0,  0, 0, 0, 2'b00},
    '{OP_DONE,   0, 0, 12, 12, 0,  0, 0, 0,  0, 0, 0, 2'b00},
    '{OP_ADV,    0, 1,  0,  0, 0,  0, 1, 0,  0, 0, 1, 2'b00},
    '{OP_COMMIT, 0, 0,  0,  0, 0,  0, 1, 0,  0, 0, 1, 2'b00},
    // Same address, different word per group
    '{OP_ADV,    0, 1, 20, 20, 0,  0, 1, 0,  0, 0, 0, 2'b00},
    '{OP_COMMIT, 0, 0,  0, 20, 0, 20, 1, 0, 20, 0, 0, 2'b00},
    '{OP_ADV,    0, 1, 20, 20, 0,  0, 1, 0,  0, 0, 0, 2'b00},
    '{OP_COMMIT, 0, 0,  0, 20, 0, 20, 1, 0, 20, 1, 0, 2'b00},
    '{OP_ADV,    0, 0,  0, 20, 1, 20, 0, 0,  0, 0, 0, 2'b00},
    // Held operands, replacement and same-cycle forwarding
    '{OP_ADV,    0, 1, 40,  0, 0,  0, 1, 0,  0, 0, 0, 2'b00},
    '{OP_ADV,    0, 1, 41,  0, 0,  0, 1, 0,  0, 0, 0, 2'b00},
    '{OP_ADV,    0, 0,  0, 40, 0, 40, 1, 0,  0, 0, 0, 2'b00},
    '{OP_COMMIT, 0, 0,  0, 40, 0, 40, 1, 0, 41, 0, 0, 2'b00},
    '{OP_COMMIT, 0, 0,  0, 40, 0, 40, 1, 0, 40, 1, 0, 2'b00},
    '{OP_ADV,    0, 1, 44,  0, 0,  0, 1, 0,  0, 0, 0, 2'b00},
    '{OP_ADV,    0, 0,  0, 44, 0, 44, 1, 1, 44, 0, 0, 2'b00},
    // Flushed advance leaves rd free
    '{OP_ADV,    1, 1, 50, 50, 0, 50, 1, 0,  0, 0, 1, 2'b00},
    '{OP_IDLE,   0, 0,  0, 50, 0,  0, 1, 0,  0, 0, 0, 2'b00},
    // Clear on request, one register still in use
    '{OP_ADV,    0, 1, 60, 60, 0,  0, 1, 0,  0, 0, 0, 2'b00},
    '{OP_CLEAR,  0, 0,  0,  0, 0,  0, 1, 0,  0, 0, 0, 2'b00},
    '{OP_ADV,    0, 0,  0, 20, 1, 40, 0, 0,  0, 0, 1, 2'b00}
};

`endif

/* test/tb_regfile.sv */
/*
 * Register file testbench
 * Table-driven stimulus against a model of banks, in-use bits and held operands
 */
module tb_regfile;
    timeunit 1ns;
    timeprecision 1ps;
    import regfile_pkg::*;

    localparam int PHYS_REGS     = 64;
    localparam int NUM_WB_GROUPS = 2;
    localparam int CLK_PERIOD    = 8;
    localparam int READY_TIMEOUT = 200;

    `include "tb_regfile_vectors.svh"

    logic        clk;
    logic        arst_n;
    logic        clear_req;
    logic        flush;
    decode_req_t decode;
    issue_req_t  issue;
    wb_packet_t  commit [NUM_WB_GROUPS];
    logic        ready;
    issue_rsp_t  operand;

    // Reference model
    logic [DATA_W-1:0] m_bank  [NUM_WB_GROUPS][PHYS_REGS];
    logic              m_inuse [PHYS_REGS];
    logic [DATA_W-1:0] m_held  [READ_PORTS];
    phys_addr_t        m_addr  [READ_PORTS];
    logic              m_grp   [READ_PORTS];

    int errors  = 0;
    int seed    = 74;
    bit aborted = 1'b0;

    regfile_top #(
        .PHYS_REGS     (PHYS_REGS),
        .NUM_WB_GROUPS (NUM_WB_GROUPS)
    ) uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear_req (clear_req),
        .flush     (flush),
        .decode    (decode),
        .issue     (issue),
        .commit    (commit),
        .ready     (ready),
        .operand   (operand)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Model updates

    function automatic void model_clear();
        for (int a = 0; a < PHYS_REGS; a++) begin
            m_inuse[a] = 1'b0;
            for (int g = 0; g < NUM_WB_GROUPS; g++) begin
                m_bank[g][a] = '0;
            end
        end
    endfunction

    // One clock edge of the rules, capture reads the bank before the write
    function automatic void model_step(input vec_t v, input logic cmt_on,
                                       input logic [DATA_W-1:0] cdata);
        logic       cmt_ok;
        phys_addr_t a;
        logic       g;
        cmt_ok = cmt_on && (v.c_addr != '0);
        for (int i = 0; i < READ_PORTS; i++) begin
            a = (i == 0) ? v.rs0 : v.rs1;
            g = (i == 0) ? v.g0 : v.g1;
            if (v.op == OP_ADV) begin
                m_addr[i] = a;
                m_grp[i]  = g;
                // Same-cycle commit wins over the old word
                if (cmt_ok && v.c_grp == g && v.c_addr == a) begin
                    m_held[i] = cdata;
                end else begin
                    m_held[i] = m_bank[g][a];
                end
            end else if (cmt_ok && v.c_grp == m_grp[i] && v.c_addr == m_addr[i]) begin
                m_held[i] = cdata;
            end
        end
        // Every update flips the in-use bit
        if (cmt_ok) begin
            m_bank[v.c_grp][v.c_addr] = cdata;
            m_inuse[v.c_addr] = !m_inuse[v.c_addr];
        end
        if (v.op == OP_ADV && v.uses_rd && v.rd != '0 && !v.flush) begin
            m_inuse[v.rd] = !m_inuse[v.rd];
        end
        if (v.op == OP_DONE) begin
            m_inuse[v.rd] = !m_inuse[v.rd];
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checks

    task automatic check_outputs(input vec_t v);
        logic [DATA_W-1:0] exp_data  [READ_PORTS];
        logic              exp_inuse [READ_PORTS];
        for (int i = 0; i < READ_PORTS; i++) begin
            if (v.fixed) begin
                exp_data[i]  = '0;
                exp_inuse[i] = v.exp_inuse[i];
            end else begin
                exp_data[i]  = m_held[i];
                exp_inuse[i] = m_inuse[(i == 0) ? v.rs0 : v.rs1];
            end
            if (operand.data[i] !== exp_data[i]) begin
                errors++;
                $display("Mismatch at %0t: port %0d data %h, expected %h",
                         $time, i, operand.data[i], exp_data[i]);
            end
            if (operand.inuse[i] !== exp_inuse[i]) begin
                errors++;
                $display("Mismatch at %0t: port %0d inuse %b, expected %b",
                         $time, i, operand.inuse[i], exp_inuse[i]);
            end
        end
        if (ready !== 1'b1) begin
            errors++;
            $display("Mismatch at %0t: ready %b outside a clear", $time, ready);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic apply_entry(input vec_t v);
        logic              cmt_on;
        logic [DATA_W-1:0] cdata;
        cmt_on = (v.op == OP_COMMIT) || (v.op == OP_ADV && v.cmt);
        cdata  = $random(seed);
        decode.advance        = (v.op == OP_ADV);
        decode.uses_rd        = v.uses_rd;
        decode.rd_addr        = v.rd;
        decode.rs_addr[0]     = v.rs0;
        decode.rs_addr[1]     = v.rs1;
        decode.rs_group[0]    = v.g0;
        decode.rs_group[1]    = v.g1;
        issue.done            = (v.op == OP_DONE);
        issue.rd_addr         = v.rd;
        issue.rs_addr[0]      = v.rs0;
        issue.rs_addr[1]      = v.rs1;
        flush                 = v.flush;
        commit[v.c_grp].valid = cmt_on;
        commit[v.c_grp].addr  = v.c_addr;
        commit[v.c_grp].data  = cdata;
        @(posedge clk);
        model_step(v, cmt_on, cdata);
        #1;
        check_outputs(v);
        // Strobes last one cycle
        decode.advance        = 1'b0;
        issue.done            = 1'b0;
        flush                 = 1'b0;
        commit[v.c_grp].valid = 1'b0;
    endtask

    task automatic wait_ready(input int expect_cycles);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < READY_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (ready !== 1'b1) begin
            errors++;
            aborted = 1'b1;
            $display("Timeout: ready did not rise within %0d cycles", READY_TIMEOUT);
        end else if (n != expect_cycles) begin
            errors++;
            $display("Mismatch at %0t: ready after %0d cycles, expected %0d",
                     $time, n, expect_cycles);
        end
    endtask

    // Both groups at every address read zero and free
    task automatic sweep_zero();
        vec_t v;
        for (int a = 0; a < PHYS_REGS; a++) begin
            v       = '0;
            v.op    = OP_ADV;
            v.rs0   = a[5:0];
            v.rs1   = a[5:0];
            v.g1    = 1'b1;
            v.fixed = 1'b1;
            apply_entry(v);
        end
    endtask

    task automatic run_clear();
        clear_req = 1'b1;
        @(posedge clk);
        #1;
        clear_req = 1'b0;
        if (ready !== 1'b0) begin
            errors++;
            $display("Mismatch at %0t: ready %b after clear request", $time, ready);
        end
        model_clear();
        wait_ready(PHYS_REGS);
        if (!aborted) begin
            sweep_zero();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        clear_req = 1'b0;
        flush     = 1'b0;
        decode    = '0;
        issue     = '0;
        for (int g = 0; g < NUM_WB_GROUPS; g++) begin
            commit[g] = '0;
        end
        for (int i = 0; i < READ_PORTS; i++) begin
            m_held[i] = '0;
            m_addr[i] = '0;
            m_grp[i]  = 1'b0;
        end
        model_clear();

        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        if (ready !== 1'b0 || operand !== '0) begin
            errors++;
            $display("Mismatch at %0t: ready %b operand %h after reset, expected zero",
                     $time, ready, operand);
        end
        // Idle cycle plus the full walk
        wait_ready(PHYS_REGS + 1);
        if (!aborted) begin
            sweep_zero();
        end

        for (int i = 0; i < NUM_VECS && !aborted; i++) begin
            if (vecs[i].op == OP_CLEAR) begin
                run_clear();
            end else begin
                apply_entry(vecs[i]);
            end
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+test
hdl/regfile_pkg.sv
hdl/toggle_memory.sv
hdl/register_bank.sv
hdl/init_sequencer.sv
hdl/init_counter.sv
hdl/register_file.sv
hdl/regfile_top.sv
test/tb_regfile.sv

/* Bender.yml */
package:
  name: regfile

sources:
  - files:
      - hdl/regfile_pkg.sv
      - hdl/toggle_memory.sv
      - hdl/register_bank.sv
      - hdl/init_sequencer.sv
      - hdl/init_counter.sv
      - hdl/register_file.sv
      - hdl/regfile_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_regfile.sv
